//--- dcache_interface.f
src/lsu_pkg.sv
src/dcache_pkg.sv
src/mem_op_decoder.sv
src/dcache_req_ctrl.sv
src/load_align.sv
src/dcache_interface.sv
test/tb_checker.sv
test/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log for failure
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wall \
    --top-module tb_top \
    -f dcache_interface.f \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

if ! grep -q "All tests passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0

//--- test/tb_top.sv
/* Testbench top for the load/store front end: clock, reset, random core
   requests from a fixed seed and a cache responder with random delays */
`timescale 1ns/1ns

module tb_top;

    import lsu_pkg::*;
    import dcache_pkg::*;

    localparam int NUM_OPS      = 400;
    localparam int CYCLE_LIMIT  = NUM_OPS * 20;

    logic        clk_i = 1'b0;
    logic        rstn_i;
    logic        req_valid_i;
    instr_type_t instr_type_i;
    xlen_t       rs1_i, imm_i, rs2_i;
    logic        resp_ready_o, lock_o;
    xlen_t       resp_data_o;
    addr_t       resp_addr_o;
    logic        ld_req_valid_o, ld_gnt_i, ld_resp_valid_i;
    dc_index_t   ld_req_index_o, st_req_index_o;
    dc_tag_t     ld_req_tag_o, st_req_tag_o;
    byte_en_t    ld_req_be_o, st_req_be_o;
    size_t       ld_req_size_o, st_req_size_o, amo_req_size_o;
    xlen_t       ld_resp_data_i, st_req_wdata_o, amo_req_operand_o, amo_resp_data_i;
    logic        st_req_valid_o, st_gnt_i, amo_req_valid_o, amo_ack_i;
    amo_op_t     amo_req_op_o;
    addr_t       amo_req_addr_o;
    int          err_count_o, done_count_o;

    xlen_t       mem [256];   // Doublewords at address bits [10:3]
    int          cycles;

    dcache_interface u_dut (.*);
    tb_checker u_checker (.*);

    always #50 clk_i = ~clk_i;

    function automatic int unsigned access_log2(instr_type_t t);
        case (t)
            LB, LBU, SB: return 0;
            LH, LHU, SH: return 1;
            LW, LWU, SW: return 2;
            LD, SD:      return 3;
            default: return (t inside {AMO_LRW, AMO_SCW, AMO_SWAPW, AMO_ADDW, AMO_XORW,
                                       AMO_ANDW, AMO_ORW, AMO_MINW, AMO_MAXW, AMO_MINUW,
                                       AMO_MAXUW}) ? 2 : 3;
        endcase
    endfunction

    // New memory value of an atomic, W forms work on the low 32 bits
    function automatic xlen_t amo_new_value(amo_op_t op, xlen_t a, xlen_t b, logic w);
        xlen_t sa;
        xlen_t sb;
        sa = w ? {{32{a[31]}}, a[31:0]} : a;
        sb = w ? {{32{b[31]}}, b[31:0]} : b;
        case (op)
            AMO_LR:   return a;
            AMO_SC:   return b;
            AMO_SWAP: return b;
            AMO_ADD:  return a + b;
            AMO_XOR:  return a ^ b;
            AMO_AND:  return a & b;
            AMO_OR:   return a | b;
            AMO_MIN:  return ($signed(sa) < $signed(sb)) ? a : b;
            AMO_MAX:  return ($signed(sa) > $signed(sb)) ? a : b;
            AMO_MINU: return (w ? a[31:0] < b[31:0] : a < b) ? a : b;
            default:  return (w ? a[31:0] > b[31:0] : a > b) ? a : b;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // Core stimulus
    // ----------------------------------------------------------------------
    task automatic drive_request();
        instr_type_t t;
        logic [31:0] r;
        xlen_t       mask;
        t    = instr_type_t'(6'($urandom_range(32, 0)));
        mask = (64'd1 << access_log2(t)) - 64'd1;
        r    = $urandom;
        rs1_i = {$urandom, $urandom};
        imm_i = {{52{r[11]}}, r[11:0]};
        rs2_i = {$urandom, $urandom};
        if (t inside {LB, LH, LW, LD, LBU, LHU, LWU, SB, SH, SW, SD}) begin
            rs1_i = rs1_i - ((rs1_i + imm_i) & mask);   // Aligned sum
        end else begin
            rs1_i = rs1_i & ~mask;
        end
        instr_type_i = t;
        req_valid_i  = 1'b1;
        @(posedge clk_i);
        #10;
        req_valid_i = 1'b0;
        do @(negedge clk_i); while (!resp_ready_o);
    endtask

    initial begin
        int sent;
        void'($urandom(47));
        for (int i = 0; i < 256; i++) begin
            mem[i] = {32'(i) * 32'h9e37_79b9, ~(32'(i) * 32'h85eb_ca6b)};
        end
        {req_valid_i, ld_gnt_i, ld_resp_valid_i, st_gnt_i, amo_ack_i} = '0;
        instr_type_i = LB;
        {rs1_i, imm_i, rs2_i, ld_resp_data_i, amo_resp_data_i} = '0;
        rstn_i = 1'b0;
        repeat (8) @(posedge clk_i);
        #10 rstn_i = 1'b1;
        sent = 0;
        while (sent < NUM_OPS) begin
            @(posedge clk_i);
            #10;
            if ($urandom_range(1, 0) == 1) begin
                drive_request();
                sent++;
            end
        end
        repeat (2) @(posedge clk_i);
        $display("Checker totals: %0d operations completed, %0d errors",
                 done_count_o, err_count_o);
        if (err_count_o == 0 && done_count_o == NUM_OPS) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // ----------------------------------------------------------------------
    // Cache responder
    // ----------------------------------------------------------------------
    task automatic wait_cycles(int n);
        repeat (n) begin
            @(posedge clk_i);
            #10;
        end
    endtask

    always begin
        int   idx;
        logic w;
        @(posedge clk_i);
        #1;
        if (ld_req_valid_o) begin
            idx = int'(ld_req_index_o[10:3]);
            #9 wait_cycles($urandom_range(3, 0));
            ld_gnt_i = 1'b1;
            wait_cycles(1);
            ld_gnt_i = 1'b0;
            wait_cycles($urandom_range(4, 1) - 1);
            ld_resp_data_i  = mem[idx];
            ld_resp_valid_i = 1'b1;
            wait_cycles(1);
            ld_resp_valid_i = 1'b0;
            ld_resp_data_i  = {$urandom, $urandom};
        end else if (st_req_valid_o) begin
            idx = int'(st_req_index_o[10:3]);
            #9 wait_cycles($urandom_range(3, 0));
            for (int b = 0; b < 8; b++) begin
                if (st_req_be_o[b]) mem[idx][b*8 +: 8] = st_req_wdata_o[b*8 +: 8];
            end
            st_gnt_i = 1'b1;
            wait_cycles(1);
            st_gnt_i = 1'b0;
        end else if (amo_req_valid_o) begin
            idx = int'(amo_req_addr_o[10:3]);
            w   = (amo_req_size_o == SIZE_WORD);
            #9 wait_cycles($urandom_range(3, 0));
            if (w) begin
                amo_resp_data_i = {$urandom, mem[idx][amo_req_addr_o[2]*32 +: 32]};
                mem[idx][amo_req_addr_o[2]*32 +: 32] = 32'(amo_new_value(amo_req_op_o,
                    {32'b0, amo_resp_data_i[31:0]}, amo_req_operand_o, 1'b1));
            end else begin
                amo_resp_data_i = mem[idx];
                mem[idx] = amo_new_value(amo_req_op_o, mem[idx], amo_req_operand_o, 1'b0);
            end
            if (amo_req_op_o == AMO_SC) amo_resp_data_i = '0;   // SC always succeeds
            amo_ack_i = 1'b1;
            wait_cycles(1);
            amo_ack_i = 1'b0;
        end
    end

    // Run limit
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT + 8) begin
            $display("Timeout: the operations did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    initial cycles = 0;

endmodule

//--- test/tb_checker.sv
/* Checker for the load/store front end; samples the DUT ports on the falling
   edge, models each operation from its strobe and counts mismatches */
`timescale 1ns/1ns

module tb_checker (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  req_valid_i,
    input  lsu_pkg::instr_type_t  instr_type_i,
    input  lsu_pkg::xlen_t        rs1_i, imm_i, rs2_i,
    input  logic                  resp_ready_o, lock_o,
    input  lsu_pkg::xlen_t        resp_data_o,
    input  lsu_pkg::addr_t        resp_addr_o,
    input  logic                  ld_req_valid_o, ld_gnt_i, ld_resp_valid_i,
    input  dcache_pkg::dc_index_t ld_req_index_o, st_req_index_o,
    input  dcache_pkg::dc_tag_t   ld_req_tag_o, st_req_tag_o,
    input  dcache_pkg::byte_en_t  ld_req_be_o, st_req_be_o,
    input  dcache_pkg::size_t     ld_req_size_o, st_req_size_o, amo_req_size_o,
    input  lsu_pkg::xlen_t        ld_resp_data_i, st_req_wdata_o,
    input  lsu_pkg::xlen_t        amo_req_operand_o, amo_resp_data_i,
    input  logic                  st_req_valid_o, st_gnt_i, amo_req_valid_o, amo_ack_i,
    input  lsu_pkg::amo_op_t      amo_req_op_o,
    input  lsu_pkg::addr_t        amo_req_addr_o,
    output int                    err_count_o,
    output int                    done_count_o
);

    import lsu_pkg::*;

    instr_type_t op_type;
    xlen_t       op_rs2;
    logic [39:0] op_addr;
    int          op_size;
    logic        pending, granted;

    function automatic int exp_size(instr_type_t t);
        case (t)
            LB, LBU, SB: return 0;
            LH, LHU, SH: return 1;
            LW, LWU, SW: return 2;
            LD, SD:      return 3;
            default: return (t inside {AMO_LRW, AMO_SCW, AMO_SWAPW, AMO_ADDW, AMO_XORW,
                                       AMO_ANDW, AMO_ORW, AMO_MINW, AMO_MAXW, AMO_MINUW,
                                       AMO_MAXUW}) ? 2 : 3;
        endcase
    endfunction

    function automatic amo_op_t exp_amo_op(instr_type_t t);
        case (t)
            AMO_LRW, AMO_LRD:     return AMO_LR;
            AMO_SCW, AMO_SCD:     return AMO_SC;
            AMO_SWAPW, AMO_SWAPD: return AMO_SWAP;
            AMO_ADDW, AMO_ADDD:   return AMO_ADD;
            AMO_XORW, AMO_XORD:   return AMO_XOR;
            AMO_ANDW, AMO_ANDD:   return AMO_AND;
            AMO_ORW, AMO_ORD:     return AMO_OR;
            AMO_MINW, AMO_MIND:   return AMO_MIN;
            AMO_MAXW, AMO_MAXD:   return AMO_MAX;
            AMO_MINUW, AMO_MINUD: return AMO_MINU;
            AMO_MAXUW, AMO_MAXUD: return AMO_MAXU;
            default:              return AMO_NONE;
        endcase
    endfunction

    // Shift down to byte zero, then cut and extend
    function automatic xlen_t exp_load(xlen_t d, logic [2:0] off, int sz, logic sgn);
        xlen_t s;
        xlen_t keep;
        s    = d >> (8 * off);
        keep = (sz == 3) ? '1 : ((64'd1 << (8 << sz)) - 64'd1);
        s    = s & keep;
        if (sgn && sz < 3 && s[(8 << sz) - 1]) s = s | ~keep;
        return s;
    endfunction

    task automatic compare(string field, xlen_t exp, xlen_t got);
        if (exp !== got) begin
            $display("mismatch at %0t ns: %s expected %h got %h", $time, field, exp, got);
            err_count_o++;
        end
    endtask

    task automatic check_fields(dcache_pkg::dc_index_t idx, dcache_pkg::dc_tag_t tag,
                                dcache_pkg::byte_en_t be, dcache_pkg::size_t sz);
        compare("request index", 64'(op_addr[11:0]), 64'(idx));
        compare("request tag", 64'(op_addr[39:12]), 64'(tag));
        compare("request byte enables", 64'((8'hff >> (8 - (1 << op_size))) << op_addr[2:0]),
                64'(be));
        compare("request size", 64'(op_size), 64'(sz));
    endtask

    // ----------------------------------------------------------------------
    // Per-cycle model of the operation in flight
    // ----------------------------------------------------------------------
    task automatic check_operation();
        logic ready_exp;
        logic is_load;
        ready_exp = 1'b0;
        is_load   = op_type inside {LB, LH, LW, LD, LBU, LHU, LWU};
        if (is_load) begin
            compare("ld_req_valid_o", 64'(!granted), 64'(ld_req_valid_o));
            if (!granted) begin
                check_fields(ld_req_index_o, ld_req_tag_o, ld_req_be_o, ld_req_size_o);
                granted = ld_gnt_i;
            end else begin
                ready_exp = ld_resp_valid_i;
                if (ready_exp) compare("load result", exp_load(ld_resp_data_i, op_addr[2:0],
                    op_size, op_type inside {LB, LH, LW}), resp_data_o);
            end
        end else if (op_type inside {SB, SH, SW, SD}) begin
            compare("st_req_valid_o", 64'd1, 64'(st_req_valid_o));
            check_fields(st_req_index_o, st_req_tag_o, st_req_be_o, st_req_size_o);
            compare("store write data", op_rs2 << (8 * op_addr[2:0]), st_req_wdata_o);
            ready_exp = st_gnt_i;
            if (ready_exp) compare("store result", 64'd0, resp_data_o);
        end else begin
            compare("amo_req_valid_o", 64'd1, 64'(amo_req_valid_o));
            compare("atomic opcode", 64'(exp_amo_op(op_type)), 64'(amo_req_op_o));
            compare("atomic size", 64'(op_size), 64'(amo_req_size_o));
            compare("atomic address", 64'(op_addr), 64'(amo_req_addr_o));
            compare("atomic operand", op_rs2, amo_req_operand_o);
            ready_exp = amo_ack_i;
            if (ready_exp) compare("atomic result", (op_size == 2) ?
                {{32{amo_resp_data_i[31]}}, amo_resp_data_i[31:0]} : amo_resp_data_i,
                resp_data_o);
        end
        if (!is_load) compare("ld_req_valid_o", 64'd0, 64'(ld_req_valid_o));
        if (!(op_type inside {SB, SH, SW, SD})) compare("st_req_valid_o", 64'd0,
                                                        64'(st_req_valid_o));
        if (is_load || op_type inside {SB, SH, SW, SD}) compare("amo_req_valid_o", 64'd0,
                                                               64'(amo_req_valid_o));
        compare("resp_ready_o", 64'(ready_exp), 64'(resp_ready_o));
        compare("lock_o", 64'(!ready_exp), 64'(lock_o));
        if (ready_exp) begin
            compare("resp_addr_o", 64'(op_addr), 64'(resp_addr_o));
            done_count_o++;
            pending = 1'b0;
        end
    endtask

    initial begin
        err_count_o  = 0;
        done_count_o = 0;
        pending      = 1'b0;
    end

    always @(negedge clk_i) begin
        if (rstn_i) begin
            if (pending) begin
                check_operation();
            end else if (resp_ready_o || lock_o || ld_req_valid_o || st_req_valid_o ||
                         amo_req_valid_o) begin
                $display("Error at %0t ns: request, lock or response active while idle",
                         $time);
                err_count_o++;
            end
            if (req_valid_i) begin
                op_type = instr_type_i;
                op_rs2  = rs2_i;
                op_size = exp_size(instr_type_i);
                op_addr = (instr_type_i inside {LB, LH, LW, LD, LBU, LHU, LWU,
                                                SB, SH, SW, SD}) ? 40'(rs1_i + imm_i)
                                                                 : rs1_i[39:0];
                granted = 1'b0;
                pending = 1'b1;
            end
        end
    end

endmodule

//--- src/dcache_interface.sv
/* Load/store front end between the core and the L1 data cache; connects the
   instruction decoder, the request controller and the result aligner */
`timescale 1ns/1ns

module dcache_interface (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    // Core request
    input  logic                   req_valid_i,
    input  lsu_pkg::instr_type_t   instr_type_i,
    input  lsu_pkg::xlen_t         rs1_i,
    input  lsu_pkg::xlen_t         imm_i,
    input  lsu_pkg::xlen_t         rs2_i,
    // Core response
    output logic                   resp_ready_o,
    output lsu_pkg::xlen_t         resp_data_o,
    output lsu_pkg::addr_t         resp_addr_o,
    output logic                   lock_o,
    // Load port
    output logic                   ld_req_valid_o,
    output dcache_pkg::dc_index_t  ld_req_index_o,
    output dcache_pkg::dc_tag_t    ld_req_tag_o,
    output dcache_pkg::byte_en_t   ld_req_be_o,
    output dcache_pkg::size_t      ld_req_size_o,
    input  logic                   ld_gnt_i,
    input  logic                   ld_resp_valid_i,
    input  lsu_pkg::xlen_t         ld_resp_data_i,
    // Store port
    output logic                   st_req_valid_o,
    output dcache_pkg::dc_index_t  st_req_index_o,
    output dcache_pkg::dc_tag_t    st_req_tag_o,
    output dcache_pkg::byte_en_t   st_req_be_o,
    output dcache_pkg::size_t      st_req_size_o,
    output lsu_pkg::xlen_t         st_req_wdata_o,
    input  logic                   st_gnt_i,
    // Atomic port
    output logic                   amo_req_valid_o,
    output lsu_pkg::amo_op_t       amo_req_op_o,
    output dcache_pkg::size_t      amo_req_size_o,
    output lsu_pkg::addr_t         amo_req_addr_o,
    output lsu_pkg::xlen_t         amo_req_operand_o,
    input  logic                   amo_ack_i,
    input  lsu_pkg::xlen_t         amo_resp_data_i
);

    import lsu_pkg::*;
    import dcache_pkg::*;

    op_class_t  dec_class;
    amo_op_t    dec_amo_op;
    size_t      dec_size;
    logic       dec_signed;

    logic       done_is_load;
    size_t      lat_size;
    logic       lat_signed;
    logic [2:0] lat_offset;

    mem_op_decoder u_decoder (
        .instr_type_i (instr_type_i),
        .op_class_o   (dec_class),
        .amo_op_o     (dec_amo_op),
        .size_o       (dec_size),
        .is_signed_o  (dec_signed)
    );

    dcache_req_ctrl u_req_ctrl (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .req_valid_i       (req_valid_i),
        .rs1_i             (rs1_i),
        .imm_i             (imm_i),
        .rs2_i             (rs2_i),
        .op_class_i        (dec_class),
        .amo_op_i          (dec_amo_op),
        .size_i            (dec_size),
        .is_signed_i       (dec_signed),
        .ld_gnt_i          (ld_gnt_i),
        .ld_resp_valid_i   (ld_resp_valid_i),
        .st_gnt_i          (st_gnt_i),
        .amo_ack_i         (amo_ack_i),
        .ld_req_valid_o    (ld_req_valid_o),
        .ld_req_index_o    (ld_req_index_o),
        .ld_req_tag_o      (ld_req_tag_o),
        .ld_req_be_o       (ld_req_be_o),
        .ld_req_size_o     (ld_req_size_o),
        .st_req_valid_o    (st_req_valid_o),
        .st_req_index_o    (st_req_index_o),
        .st_req_tag_o      (st_req_tag_o),
        .st_req_be_o       (st_req_be_o),
        .st_req_size_o     (st_req_size_o),
        .st_req_wdata_o    (st_req_wdata_o),
        .amo_req_valid_o   (amo_req_valid_o),
        .amo_req_op_o      (amo_req_op_o),
        .amo_req_size_o    (amo_req_size_o),
        .amo_req_addr_o    (amo_req_addr_o),
        .amo_req_operand_o (amo_req_operand_o),
        .done_o            (resp_ready_o),   // Completion strobe to the core
        .done_is_load_o    (done_is_load),
        .lat_size_o        (lat_size),
        .lat_signed_o      (lat_signed),
        .lat_offset_o      (lat_offset),
        .resp_addr_o       (resp_addr_o),
        .lock_o            (lock_o)
    );

    // A store completes on its grant
    load_align u_align (
        .done_is_load_i (done_is_load),
        .st_done_i      (st_gnt_i),
        .offset_i       (lat_offset),
        .size_i         (lat_size),
        .is_signed_i    (lat_signed),
        .ld_data_i      (ld_resp_data_i),
        .amo_data_i     (amo_resp_data_i),
        .data_o         (resp_data_o)
    );

endmodule

//--- src/load_align.sv
/* Result formatting: moves load data down to byte zero and extends load or
   atomic data by access size and signedness */
`timescale 1ns/1ns

module load_align (
    input  logic              done_is_load_i,
    input  logic              st_done_i,
    input  logic [2:0]        offset_i,
    input  dcache_pkg::size_t size_i,
    input  logic              is_signed_i,
    input  lsu_pkg::xlen_t    ld_data_i,
    input  lsu_pkg::xlen_t    amo_data_i,
    output lsu_pkg::xlen_t    data_o
);

    import lsu_pkg::*;
    import dcache_pkg::*;

    xlen_t sel_data;
    xlen_t ext_data;

    // Atomic data already sits at byte zero
    assign sel_data = done_is_load_i ? (ld_data_i >> {offset_i, 3'b000}) : amo_data_i;

    always_comb begin
        case (size_i)
            SIZE_BYTE: begin
                ext_data = is_signed_i ? {{56{sel_data[7]}}, sel_data[7:0]}
                                       : {56'b0, sel_data[7:0]};
            end
            SIZE_HALF: begin
                ext_data = is_signed_i ? {{48{sel_data[15]}}, sel_data[15:0]}
                                       : {48'b0, sel_data[15:0]};
            end
            SIZE_WORD: begin
                ext_data = is_signed_i ? {{32{sel_data[31]}}, sel_data[31:0]}
                                       : {32'b0, sel_data[31:0]};
            end
            default: ext_data = sel_data;   // Doubleword passes whole
        endcase
    end

    assign data_o = st_done_i ? '0 : ext_data;   // Stores return no data

endmodule

//--- src/dcache_req_ctrl.sv
/* Request controller: latches one memory operation on the core strobe, issues it
   on the load, store or atomic port and holds it until the cache completes it */
`timescale 1ns/1ns

module dcache_req_ctrl (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    // Core request and decoded fields
    input  logic                   req_valid_i,
    input  lsu_pkg::xlen_t         rs1_i,
    input  lsu_pkg::xlen_t         imm_i,
    input  lsu_pkg::xlen_t         rs2_i,
    input  lsu_pkg::op_class_t     op_class_i,
    input  lsu_pkg::amo_op_t       amo_op_i,
    input  dcache_pkg::size_t      size_i,
    input  logic                   is_signed_i,
    // Cache events
    input  logic                   ld_gnt_i,
    input  logic                   ld_resp_valid_i,
    input  logic                   st_gnt_i,
    input  logic                   amo_ack_i,
    // Load request
    output logic                   ld_req_valid_o,
    output dcache_pkg::dc_index_t  ld_req_index_o,
    output dcache_pkg::dc_tag_t    ld_req_tag_o,
    output dcache_pkg::byte_en_t   ld_req_be_o,
    output dcache_pkg::size_t      ld_req_size_o,
    // Store request
    output logic                   st_req_valid_o,
    output dcache_pkg::dc_index_t  st_req_index_o,
    output dcache_pkg::dc_tag_t    st_req_tag_o,
    output dcache_pkg::byte_en_t   st_req_be_o,
    output dcache_pkg::size_t      st_req_size_o,
    output lsu_pkg::xlen_t         st_req_wdata_o,
    // Atomic request
    output logic                   amo_req_valid_o,
    output lsu_pkg::amo_op_t       amo_req_op_o,
    output dcache_pkg::size_t      amo_req_size_o,
    output lsu_pkg::addr_t         amo_req_addr_o,
    output lsu_pkg::xlen_t         amo_req_operand_o,
    // To the aligner
    output logic                   done_o,
    output logic                   done_is_load_o,
    output dcache_pkg::size_t      lat_size_o,
    output logic                   lat_signed_o,
    output logic [2:0]             lat_offset_o,
    // To the core
    output lsu_pkg::addr_t         resp_addr_o,
    output logic                   lock_o
);

    import lsu_pkg::*;
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LD_REQ,
        LD_WAIT,
        ST_REQ,
        AMO_REQ
    } state_t;

    state_t   state_q, state_d;
    logic     accept;
    xlen_t    addr_sum;
    addr_t    eff_addr;

    // Latched operation
    addr_t    lat_addr;
    xlen_t    lat_operand;
    amo_op_t  lat_amo_op;
    size_t    lat_size;
    logic     lat_signed;

    dc_index_t req_index;
    dc_tag_t   req_tag;
    byte_en_t  size_mask;
    byte_en_t  req_be;

    // ----------------------------------------------------------------------
    // Effective address and operation latch
    // ----------------------------------------------------------------------
    assign addr_sum = rs1_i + imm_i;
    assign eff_addr = (op_class_i == OP_AMO) ? rs1_i[ADDR_WIDTH-1:0]   // No offset for atomics
                                             : addr_sum[ADDR_WIDTH-1:0];

    // Core may strobe in idle or in the completion cycle
    assign accept = req_valid_i && !lock_o;

    always_ff @(posedge clk_i) begin
        if (accept) begin
            lat_addr    <= eff_addr;
            lat_operand <= rs2_i;
            lat_amo_op  <= amo_op_i;
            lat_size    <= size_i;
            lat_signed  <= is_signed_i;
        end
    end

    // ----------------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------------
    assign done_o = (state_q == LD_WAIT && ld_resp_valid_i) ||
                    (state_q == ST_REQ  && st_gnt_i)        ||
                    (state_q == AMO_REQ && amo_ack_i);

    always_comb begin
        state_d = state_q;
        if (state_q == LD_REQ && ld_gnt_i) begin
            state_d = LD_WAIT;   // Data follows later
        end
        if (done_o) begin
            state_d = IDLE;
        end
        if (accept) begin
            case (op_class_i)
                OP_LOAD:  state_d = LD_REQ;
                OP_STORE: state_d = ST_REQ;
                OP_AMO:   state_d = AMO_REQ;
                default:  state_d = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign lock_o         = (state_q != IDLE) && !done_o;
    assign done_is_load_o = (state_q == LD_WAIT);

    // ----------------------------------------------------------------------
    // Request fields from the latched operation
    // ----------------------------------------------------------------------
    assign req_index = lat_addr[DCACHE_INDEX_WIDTH-1:0];
    assign req_tag   = lat_addr[ADDR_WIDTH-1:DCACHE_INDEX_WIDTH];

    always_comb begin
        case (lat_size)
            SIZE_BYTE: size_mask = 8'h01;
            SIZE_HALF: size_mask = 8'h03;
            SIZE_WORD: size_mask = 8'h0f;
            default:   size_mask = 8'hff;
        endcase
    end

    assign req_be = size_mask << lat_addr[2:0];

    assign ld_req_valid_o = (state_q == LD_REQ);
    assign ld_req_index_o = req_index;
    assign ld_req_tag_o   = req_tag;
    assign ld_req_be_o    = req_be;
    assign ld_req_size_o  = lat_size;

    assign st_req_valid_o = (state_q == ST_REQ);
    assign st_req_index_o = req_index;
    assign st_req_tag_o   = req_tag;
    assign st_req_be_o    = req_be;
    assign st_req_size_o  = lat_size;
    assign st_req_wdata_o = lat_operand << {lat_addr[2:0], 3'b000};   // Move to byte lane

    assign amo_req_valid_o   = (state_q == AMO_REQ);
    assign amo_req_op_o      = lat_amo_op;
    assign amo_req_size_o    = lat_size;
    assign amo_req_addr_o    = lat_addr;
    assign amo_req_operand_o = lat_operand;

    assign lat_size_o   = lat_size;
    assign lat_signed_o = lat_signed;
    assign lat_offset_o = lat_addr[2:0];
    assign resp_addr_o  = lat_addr;

endmodule

//--- src/mem_op_decoder.sv
/* Combinational decode of the core's memory instruction into operation class,
   atomic opcode, access size and signedness */
`timescale 1ns/1ns

module mem_op_decoder (
    input  lsu_pkg::instr_type_t instr_type_i,
    output lsu_pkg::op_class_t   op_class_o,
    output lsu_pkg::amo_op_t     amo_op_o,
    output dcache_pkg::size_t    size_o,
    output logic                 is_signed_o
);

    import lsu_pkg::*;
    import dcache_pkg::*;

    logic amo_dword;   // D form of an atomic

    assign amo_dword = instr_type_i inside {AMO_LRD, AMO_SCD, AMO_SWAPD, AMO_ADDD,
                                            AMO_XORD, AMO_ANDD, AMO_ORD, AMO_MIND,
                                            AMO_MAXD, AMO_MINUD, AMO_MAXUD};

    always_comb begin
        op_class_o  = OP_NOP;   // Unknown codes fall through as NOP
        amo_op_o    = AMO_NONE;
        size_o      = SIZE_BYTE;
        is_signed_o = 1'b0;
        case (instr_type_i)
            // Loads
            LB:  begin op_class_o = OP_LOAD; size_o = SIZE_BYTE;   is_signed_o = 1'b1; end
            LH:  begin op_class_o = OP_LOAD; size_o = SIZE_HALF;   is_signed_o = 1'b1; end
            LW:  begin op_class_o = OP_LOAD; size_o = SIZE_WORD;   is_signed_o = 1'b1; end
            LD:  begin op_class_o = OP_LOAD; size_o = SIZE_DOUBLE; end
            LBU: begin op_class_o = OP_LOAD; size_o = SIZE_BYTE;   end
            LHU: begin op_class_o = OP_LOAD; size_o = SIZE_HALF;   end
            LWU: begin op_class_o = OP_LOAD; size_o = SIZE_WORD;   end
            // Stores
            SB:  begin op_class_o = OP_STORE; size_o = SIZE_BYTE;   end
            SH:  begin op_class_o = OP_STORE; size_o = SIZE_HALF;   end
            SW:  begin op_class_o = OP_STORE; size_o = SIZE_WORD;   end
            SD:  begin op_class_o = OP_STORE; size_o = SIZE_DOUBLE; end
            // Atomics, W and D forms share the opcode
            AMO_LRW,   AMO_LRD:   amo_op_o = AMO_LR;
            AMO_SCW,   AMO_SCD:   amo_op_o = AMO_SC;
            AMO_SWAPW, AMO_SWAPD: amo_op_o = AMO_SWAP;
            AMO_ADDW,  AMO_ADDD:  amo_op_o = AMO_ADD;
            AMO_XORW,  AMO_XORD:  amo_op_o = AMO_XOR;
            AMO_ANDW,  AMO_ANDD:  amo_op_o = AMO_AND;
            AMO_ORW,   AMO_ORD:   amo_op_o = AMO_OR;
            AMO_MINW,  AMO_MIND:  amo_op_o = AMO_MIN;
            AMO_MAXW,  AMO_MAXD:  amo_op_o = AMO_MAX;
            AMO_MINUW, AMO_MINUD: amo_op_o = AMO_MINU;
            AMO_MAXUW, AMO_MAXUD: amo_op_o = AMO_MAXU;
            default: ;
        endcase

        if (amo_op_o != AMO_NONE) begin
            op_class_o  = OP_AMO;
            size_o      = amo_dword ? SIZE_DOUBLE : SIZE_WORD;
            is_signed_o = 1'b1;   // W results sign-extend from bit 31
        end
    end

endmodule

//--- src/dcache_pkg.sv
/* Cache-side definitions: index/tag split of the address, access size codes
   and the byte-enable mask type */
package dcache_pkg;

    localparam int DCACHE_ADDR_WIDTH  = 40;
    localparam int DCACHE_INDEX_WIDTH = 12;
    localparam int DCACHE_TAG_WIDTH   = DCACHE_ADDR_WIDTH - DCACHE_INDEX_WIDTH;

    typedef logic [DCACHE_INDEX_WIDTH-1:0] dc_index_t;
    typedef logic [DCACHE_TAG_WIDTH-1:0]   dc_tag_t;

    // ----------------------------------------------------------------------
    // Access size, log2 of the byte count
    // ----------------------------------------------------------------------
    typedef logic [1:0] size_t;

    localparam size_t SIZE_BYTE   = 2'd0;
    localparam size_t SIZE_HALF   = 2'd1;
    localparam size_t SIZE_WORD   = 2'd2;
    localparam size_t SIZE_DOUBLE = 2'd3;

    typedef logic [7:0] byte_en_t;   // One bit per byte of the doubleword

endpackage

//--- src/lsu_pkg.sv
/* Core-side definitions for the load/store front end: data and address types,
   memory instruction encodings, operation classes and atomic opcodes */
package lsu_pkg;

    localparam int XLEN       = 64;
    localparam int ADDR_WIDTH = 40;

    typedef logic [XLEN-1:0]       xlen_t;   // rs1, rs2, immediate and result data
    typedef logic [ADDR_WIDTH-1:0] addr_t;   // Virtual address sent to the cache

    // ----------------------------------------------------------------------
    // Memory instructions issued by the core
    // ----------------------------------------------------------------------
    typedef enum logic [5:0] {
        LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD,
        AMO_LRW,   AMO_LRD,
        AMO_SCW,   AMO_SCD,
        AMO_SWAPW, AMO_SWAPD,
        AMO_ADDW,  AMO_ADDD,
        AMO_XORW,  AMO_XORD,
        AMO_ANDW,  AMO_ANDD,
        AMO_ORW,   AMO_ORD,
        AMO_MINW,  AMO_MIND,
        AMO_MAXW,  AMO_MAXD,
        AMO_MINUW, AMO_MINUD,
        AMO_MAXUW, AMO_MAXUD
    } instr_type_t;

    // Operation class, picks the cache port
    typedef enum logic [1:0] {
        OP_NOP,
        OP_LOAD,
        OP_STORE,
        OP_AMO
    } op_class_t;

    // Opcode sent on the atomic request port
    typedef enum logic [3:0] {
        AMO_NONE,
        AMO_LR,
        AMO_SC,
        AMO_SWAP,
        AMO_ADD,
        AMO_XOR,
        AMO_AND,
        AMO_OR,
        AMO_MIN,
        AMO_MAX,
        AMO_MINU,
        AMO_MAXU
    } amo_op_t;

endpackage
